/* Makefile */
# Verilator simulation of the SPI host testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_spi_host -f vlog.f -o sim
	./obj_dir/sim > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* hdl/byte_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_fifo import spi_pkg::*; #(
	parameter int DEPTH = TX_DEPTH
) (
	input wire      apb,
	input wire      rst_n,
	byte_stream_if.fifo q
);

	//////////////////////////////////////////////////////////////////////
	// Storage and pointers

	logic [BYTE_WIDTH-1:0]    mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [LEVEL_WIDTH-1:0]   count;

	// Status straight from the count
	assign q.full  = (count == DEPTH);
	assign q.empty = (count == '0);
	assign q.level = count;

	// Head of queue, valid whenever not empty
	assign q.pop_data = mem[rd_ptr];

	// Pointer and count update
	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (q.push) begin
				// Wrap at DEPTH, works for non power of two depths too
				if (wr_ptr == DEPTH - 1)
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end

			if (q.pop) begin
				if (rd_ptr == DEPTH - 1)
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end

			// Simultaneous push and pop leaves count alone
			if (q.push && !q.pop)
				count <= count + 1'b1;
			else if (q.pop && !q.push)
				count <= count - 1'b1;
		end
	end

	// Entry written on the push edge
	always_ff @(posedge apb) begin
		if (q.push)
			mem[wr_ptr] <= q.push_data;
	end

	//////////////////////////////////////////////////////////////////////
	// Handshake checks against writer and reader

	// Writer must respect full
	a_no_push_full: assert property (@(posedge apb) disable iff (!rst_n)
		q.push |-> !q.full);

	// Reader must respect empty
	a_no_pop_empty: assert property (@(posedge apb) disable iff (!rst_n)
		q.pop |-> !q.empty);

endmodule

`default_nettype wire

/* hdl/byte_stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface byte_stream_if import spi_pkg::*; ();

	// Write side
	logic                   push;
	logic [BYTE_WIDTH-1:0]  push_data;
	logic                   full;

	// Read side, head entry shown while not empty
	logic                   pop;
	logic [BYTE_WIDTH-1:0]  pop_data;
	logic                   empty;
	logic [LEVEL_WIDTH-1:0] level;

	// Writer also sees empty and level for status reporting
	modport writer (output push, output push_data, input full, input empty, input level);

	modport reader (output pop, input pop_data, input empty, input level);

	modport fifo (
		input  push, input  push_data, output full,
		input  pop,  output pop_data,  output empty, output level
	);

endinterface

`default_nettype wire

/* hdl/spi_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_apb_regs import spi_pkg::*; (
	input wire                    apb,
	input wire                    rst_n,

	// APB completer
	input wire                    psel,
	input wire                    penable,
	input wire                    pwrite,
	input wire  [ADDR_WIDTH-1:0]  paddr,
	input wire  [DATA_WIDTH-1:0]  pwdata,
	output logic [DATA_WIDTH-1:0] prdata,
	output logic                  pready,
	output logic                  pslverr,

	// FIFO sides
	byte_stream_if.writer         tx,
	byte_stream_if.reader         rx,

	// Shifter control and status
	input wire                    shifter_active,
	output logic [DIV_WIDTH-1:0]  clk_div,
	output logic                  spi_cs_n
);

	//////////////////////////////////////////////////////////////////////
	// Access decode

	logic                  access;
	logic                  wr_err;
	logic                  rd_err;
	logic                  wr_ok;
	logic                  busy;
	logic [DATA_WIDTH-1:0] rd_word;
	logic [DATA_WIDTH-1:0] status_word;

	// No wait states, every access completes in its access phase
	assign access = psel & penable;
	assign pready = access;

	// Write side errors
	always_comb begin
		case (paddr)
			REG_CLK_DIV: wr_err = 1'b0;
			// No room for another byte
			REG_DATA:    wr_err = tx.full;
			REG_CS_N:    wr_err = 1'b0;
			// Read only
			REG_STATUS:  wr_err = 1'b1;
			// Unmapped
			default:     wr_err = 1'b1;
		endcase
	end

	// Busy covers queued bytes as well as the byte on the wire
	assign busy = shifter_active | !tx.empty;

	// Status word assembly
	always_comb begin
		status_word                                       = '0;
		status_word[STAT_BUSY]                            = busy;
		status_word[STAT_TX_FULL]                         = tx.full;
		status_word[STAT_RX_EMPTY]                        = rx.empty;
		status_word[STAT_TX_LVL_LSB +: LEVEL_WIDTH]       = tx.level;
		status_word[STAT_RX_LVL_LSB +: LEVEL_WIDTH]       = rx.level;
	end

	// Read mux and read side errors
	always_comb begin
		rd_err  = 1'b0;
		rd_word = '0;
		case (paddr)
			REG_CLK_DIV: rd_word = {{(DATA_WIDTH-DIV_WIDTH){1'b0}}, clk_div};
			REG_DATA: begin
				// Nothing received yet
				rd_err  = rx.empty;
				rd_word = {{(DATA_WIDTH-BYTE_WIDTH){1'b0}}, rx.pop_data};
			end
			REG_CS_N:    rd_word = {{(DATA_WIDTH-1){1'b0}}, spi_cs_n};
			REG_STATUS:  rd_word = status_word;
			default:     rd_err  = 1'b1;
		endcase
	end

	// Error only flagged in the completing cycle
	assign pslverr = access & (pwrite ? wr_err : rd_err);

	// Failed or idle reads return zero
	assign prdata = (access && !pwrite && !rd_err) ? rd_word : '0;

	//////////////////////////////////////////////////////////////////////
	// FIFO handshakes

	assign wr_ok = access & pwrite & !wr_err;

	// Transmit byte enters TX on the access edge
	assign tx.push      = wr_ok & (paddr == REG_DATA);
	assign tx.push_data = pwdata[BYTE_WIDTH-1:0];

	// Receive head consumed by a good DATA read
	assign rx.pop = access & !pwrite & !rd_err & (paddr == REG_DATA);

	//////////////////////////////////////////////////////////////////////
	// Control registers

	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			clk_div  <= CLK_DIV_RESET;
			spi_cs_n <= CS_N_RESET;
		end else if (wr_ok) begin
			case (paddr)
				REG_CLK_DIV: clk_div  <= pwdata[DIV_WIDTH-1:0];
				// Chip select is purely software driven
				REG_CS_N:    spi_cs_n <= pwdata[0];
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/spi_host_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_host_top import spi_pkg::*; (
	input wire                    apb,
	input wire                    rst_n,

	// APB completer
	input wire                    psel,
	input wire                    penable,
	input wire                    pwrite,
	input wire  [ADDR_WIDTH-1:0]  paddr,
	input wire  [DATA_WIDTH-1:0]  pwdata,
	output logic [DATA_WIDTH-1:0] prdata,
	output logic                  pready,
	output logic                  pslverr,

	// SPI host pins
	output logic                  spi_sck,
	output logic                  spi_mosi,
	input wire                    spi_miso,
	output logic                  spi_cs_n
);

	//////////////////////////////////////////////////////////////////////
	// Internal links

	// Registers to shifter, and back
	byte_stream_if tx_if ();
	byte_stream_if rx_if ();

	logic                 shifter_active;
	logic [DIV_WIDTH-1:0] clk_div;

	//////////////////////////////////////////////////////////////////////
	// Register block

	spi_apb_regs i_spi_apb_regs (
		.apb            (apb),
		.rst_n          (rst_n),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.paddr          (paddr),
		.pwdata         (pwdata),
		.prdata         (prdata),
		.pready         (pready),
		.pslverr        (pslverr),
		.tx             (tx_if.writer),
		.rx             (rx_if.reader),
		.shifter_active (shifter_active),
		.clk_div        (clk_div),
		.spi_cs_n       (spi_cs_n)
	);

	//////////////////////////////////////////////////////////////////////
	// Byte buffers

	byte_fifo #(.DEPTH(TX_DEPTH)) tx_fifo (
		.apb   (apb),
		.rst_n (rst_n),
		.q     (tx_if.fifo)
	);

	byte_fifo #(.DEPTH(RX_DEPTH)) rx_fifo (
		.apb   (apb),
		.rst_n (rst_n),
		.q     (rx_if.fifo)
	);

	//////////////////////////////////////////////////////////////////////
	// Shift engine

	spi_shifter i_spi_shifter (
		.apb            (apb),
		.rst_n          (rst_n),
		.clk_div        (clk_div),
		.tx             (tx_if.reader),
		.rx             (rx_if.writer),
		.spi_sck        (spi_sck),
		.spi_mosi       (spi_mosi),
		.spi_miso       (spi_miso),
		.shifter_active (shifter_active)
	);

endmodule

`default_nettype wire

/* hdl/spi_pkg.sv */
`default_nettype none

package spi_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus and datapath widths

	// APB completer side
	localparam int ADDR_WIDTH = 8;
	localparam int DATA_WIDTH = 32;

	// One SPI frame is one byte
	localparam int BYTE_WIDTH = 8;

	// SCK divider register
	localparam int DIV_WIDTH = 16;

	//////////////////////////////////////////////////////////////////////
	// FIFO sizing

	localparam int TX_DEPTH = 4;
	localparam int RX_DEPTH = 4;

	// Fill level has to hold 0 through DEPTH
	localparam int LEVEL_WIDTH = 3;

	//////////////////////////////////////////////////////////////////////
	// Reset values

	localparam logic [DIV_WIDTH-1:0] CLK_DIV_RESET = 16'd100;

	// Chip select comes out of reset deasserted
	localparam logic CS_N_RESET = 1'b1;

	//////////////////////////////////////////////////////////////////////
	// Register map, registers on 0x20 boundaries

	typedef enum logic [ADDR_WIDTH-1:0] {
		REG_CLK_DIV = 8'h00,
		REG_DATA    = 8'h20,
		REG_CS_N    = 8'h40,
		REG_STATUS  = 8'h60
	} reg_addr_t;

	// STATUS bit layout
	localparam int STAT_BUSY       = 0;
	localparam int STAT_TX_FULL    = 1;
	localparam int STAT_RX_EMPTY   = 2;
	localparam int STAT_TX_LVL_LSB = 4;
	localparam int STAT_RX_LVL_LSB = 8;

endpackage

`default_nettype wire

/* hdl/spi_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_shifter import spi_pkg::*; (
	input wire                   apb,
	input wire                   rst_n,
	input wire  [DIV_WIDTH-1:0]  clk_div,

	// Bytes in from TX, bytes out to RX
	byte_stream_if.reader        tx,
	byte_stream_if.writer        rx,

	// SPI pins, mode 0
	output logic                 spi_sck,
	output logic                 spi_mosi,
	input wire                   spi_miso,

	output logic                 shifter_active
);

	//////////////////////////////////////////////////////////////////////
	// Frame sequencing

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SHIFT,
		ST_PUSH
	} state_t;

	state_t                 state;
	logic [DIV_WIDTH-1:0]   half;
	logic [DIV_WIDTH-1:0]   div_cnt;
	logic                   tick;
	logic                   sck_q;
	logic [3:0]             edge_cnt;
	logic [BYTE_WIDTH-1:0]  tx_shreg;
	logic [BYTE_WIDTH-1:0]  rx_shreg;
	logic                   start;

	// Divide by zero runs as divide by one
	assign half = (clk_div == '0) ? DIV_WIDTH'(1) : clk_div;

	// End of a half period, >= so a divider change mid-byte cannot stall
	assign tick = (state == ST_SHIFT) && (div_cnt >= half - 1'b1);

	// Only start when the answer byte is sure to fit in RX
	assign start  = (state == ST_IDLE) && !tx.empty && !rx.full;
	assign tx.pop = start;

	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			div_cnt  <= '0;
			sck_q    <= 1'b0;
			edge_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						state    <= ST_SHIFT;
						div_cnt  <= '0;
						edge_cnt <= '0;
					end
				end
				ST_SHIFT: begin
					if (tick) begin
						div_cnt  <= '0;
						sck_q    <= !sck_q;
						edge_cnt <= edge_cnt + 1'b1;
						// 16th edge is the last falling edge
						if (edge_cnt == 4'(2*BYTE_WIDTH-1))
							state <= ST_PUSH;
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				// One cycle to hand the received byte to RX
				ST_PUSH: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Shift registers

	always_ff @(posedge apb) begin
		// Load from the TX head on the pop edge
		if (start)
			tx_shreg <= tx.pop_data;
		// Falling edge moves the next bit onto MOSI
		else if (tick && sck_q)
			tx_shreg <= {tx_shreg[BYTE_WIDTH-2:0], 1'b0};

		// Rising edge samples MISO, MSB first
		if (tick && !sck_q)
			rx_shreg <= {rx_shreg[BYTE_WIDTH-2:0], spi_miso};
	end

	assign rx.push      = (state == ST_PUSH);
	assign rx.push_data = rx_shreg;

	assign spi_sck        = sck_q;
	// MSB already on the pin ahead of the first rising edge
	assign spi_mosi       = (state == ST_SHIFT) & tx_shreg[BYTE_WIDTH-1];
	assign shifter_active = (state != ST_IDLE);

	//////////////////////////////////////////////////////////////////////
	// Checks

	// Clock parked low between bytes
	a_sck_idle_low: assert property (@(posedge apb) disable iff (!rst_n)
		(state == ST_IDLE) |-> !sck_q);

endmodule

`default_nettype wire

/* testbench/spi_device_model.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_device_model (
	input wire   spi_sck,
	input wire   spi_mosi,
	output logic spi_miso
);

	// Every byte seen on MOSI, oldest first
	logic [7:0] mosi_log [$];

	logic [7:0] in_sh = 8'h00;
	// First answer before anything was received
	logic [7:0] out_sh = 8'h5A;
	int         bit_cnt = 0;
	logic       answer_due = 1'b0;

	// MSB of the answer being shifted sits on the pin, from the start on
	assign spi_miso = out_sh[7];

	// Mode 0, host data valid on the rising edge
	always @(posedge spi_sck) begin
		in_sh = {in_sh[6:0], spi_mosi};
		bit_cnt++;
		if (bit_cnt == 8) begin
			mosi_log.push_back(in_sh);
			bit_cnt = 0;
			answer_due = 1'b1;
		end
	end

	// Falling edge moves the next answer bit out
	always @(negedge spi_sck) begin
		if (answer_due) begin
			// Next answer is the inverse of the byte just taken
			out_sh = ~mosi_log[mosi_log.size()-1];
			answer_due = 1'b0;
		end else if (bit_cnt != 0) begin
			out_sh = {out_sh[6:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

/* testbench/tb_spi_host.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spi_host import spi_pkg::*; ();

	//////////////////////////////////////////////////////////////////////
	// Run constants

	// Slow divider for the overflow burst
	localparam int BURST_DIV = 50;
	localparam int FAST_DIV  = 2;
	// Bytes moved over the whole run
	localparam int RUN_BYTES = 15;
	// Bytes x 16 half periods x divider x 20 ns, margin of 4
	localparam longint WATCHDOG_NS = longint'(RUN_BYTES) * 16 * BURST_DIV * 20 * 4;
	localparam int POLL_LIMIT = 5000;

	logic                  apb;
	logic                  rst_n;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [ADDR_WIDTH-1:0] paddr;
	logic [DATA_WIDTH-1:0] pwdata;
	logic [DATA_WIDTH-1:0] prdata;
	logic                  pready;
	logic                  pslverr;
	logic                  spi_sck;
	logic                  spi_mosi;
	logic                  spi_cs_n;
	wire                   spi_miso;

	// Accepted transmit bytes, and DATA reads waiting for the compare
	logic [7:0] sent_hist [$];
	logic [7:0] rd_log [$];
	logic [31:0] lfsr_state = 32'hb92c;
	int checks = 0;
	int errors = 0;
	int test_num = 0;
	int errs_at_start = 0;
	int cmp_idx = 0;
	int cs_changes = 0;
	// SCK half period in clock cycles that the last CLK_DIV write asks for
	int exp_half = CLK_DIV_RESET;
	int sck_edges = 0;
	time last_sck_edge = 0;

	spi_host_top i_spi_host_top (
		.apb(apb), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .spi_sck(spi_sck), .spi_mosi(spi_mosi),
		.spi_miso(spi_miso), .spi_cs_n(spi_cs_n)
	);

	spi_device_model i_spi_device_model (
		.spi_sck(spi_sck), .spi_mosi(spi_mosi), .spi_miso(spi_miso)
	);

	initial begin
		apb = 1'b0;
		forever #10 apb = ~apb;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model and checking

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One step per bit taken
	task automatic next_rand_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			b = {b[6:0], lfsr_state[0]};
		end
	endtask

	// Device answers 0x5A first, then the inverse of the byte before
	function automatic logic [7:0] expected_answer(input int idx);
		if (idx == 0)
			return 8'h5A;
		return ~sent_hist[idx-1];
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
		end
	endtask

	// k-th good DATA read belongs to the k-th byte sent
	initial begin : compare_rx
		logic [7:0] got;
		forever begin
			@(posedge apb);
			while (rd_log.size() > 0) begin
				got = rd_log.pop_front();
				check("RX byte", got, expected_answer(cmp_idx));
				cmp_idx++;
			end
		end
	end

	// Counts every edge on the chip select pin
	initial begin : cs_monitor
		forever begin
			@(spi_cs_n);
			cs_changes++;
		end
	end

	// Inside a byte each SCK edge comes one half period after the one before
	initial begin : sck_timing
		@(posedge rst_n);
		forever begin
			@(spi_sck);
			if (sck_edges % 16 != 0)
				check("SCK half period in ns", 32'($time - last_sck_edge),
					32'(exp_half * 20));
			last_sck_edge = $time;
			sck_edges++;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// APB access, inputs move 2 ns after the edge

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
		output logic err);
		@(posedge apb);
		#2;
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge apb);
		#2;
		penable = 1'b1;
		#1;
		check("pready on write", pready, 1);
		err = pslverr;
		@(posedge apb);
		#2;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		// Divider of 0 runs as 1
		if (addr == REG_CLK_DIV)
			exp_half = (data[15:0] == 16'd0) ? 1 : int'(data[15:0]);
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
		output logic err);
		@(posedge apb);
		#2;
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge apb);
		#2;
		penable = 1'b1;
		#1;
		check("pready on read", pready, 1);
		data = prdata;
		err = pslverr;
		@(posedge apb);
		#2;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_expect(input logic [7:0] addr, input logic [31:0] data,
		input logic exp_err, input string what);
		logic err;
		write_reg(addr, data, err);
		check(what, err, exp_err);
	endtask

	task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp,
		input logic exp_err, input string what);
		logic [31:0] d;
		logic        err;
		read_reg(addr, d, err);
		check({what, " pslverr"}, err, exp_err);
		check(what, d, exp);
	endtask

	task automatic send_byte(input logic [7:0] b, input logic exp_err);
		logic err;
		write_reg(REG_DATA, {24'h0, b}, err);
		check("DATA write pslverr", err, exp_err);
		if (!err)
			sent_hist.push_back(b);
	endtask

	task automatic drain_rx(input int n);
		logic [31:0] d;
		logic        err;
		for (int i = 0; i < n; i++) begin
			read_reg(REG_DATA, d, err);
			check("DATA read pslverr", err, 0);
			if (!err)
				rd_log.push_back(d[7:0]);
		end
	endtask

	task automatic wait_idle();
		logic [31:0] st;
		logic        err;
		int          polls;
		polls = 0;
		do begin
			read_reg(REG_STATUS, st, err);
			polls++;
		end while (st[STAT_BUSY] && polls < POLL_LIMIT);
		if (st[STAT_BUSY]) begin
			errors++;
			$display("The host stayed busy after %0d STATUS polls", POLL_LIMIT);
		end
	endtask

	task automatic wait_rx_full();
		logic [31:0] st;
		logic        err;
		int          polls;
		polls = 0;
		do begin
			read_reg(REG_STATUS, st, err);
			polls++;
		end while (st[STAT_RX_LVL_LSB +: LEVEL_WIDTH] != RX_DEPTH && polls < POLL_LIMIT);
		if (st[STAT_RX_LVL_LSB +: LEVEL_WIDTH] != RX_DEPTH) begin
			errors++;
			$display("The receive FIFO never filled up");
		end
	endtask

	// Device must have seen exactly the accepted bytes, in order
	task automatic check_model_log();
		int n;
		n = i_spi_device_model.mosi_log.size();
		check("model byte count", n, sent_hist.size());
		for (int i = 0; i < n && i < sent_hist.size(); i++)
			check("model byte", i_spi_device_model.mosi_log[i], sent_hist[i]);
	endtask

	task automatic open_test();
		test_num++;
		errs_at_start = errors;
	endtask

	task automatic close_test(input string name);
		while (rd_log.size() > 0)
			@(posedge apb);
		$display("test %0d %s: %s, %0d errors", test_num, name,
			(errors == errs_at_start) ? "pass" : "fail", errors - errs_at_start);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests

	task automatic reset_values();
		open_test();
		read_expect(REG_CLK_DIV, 100, 0, "CLK_DIV after reset");
		read_expect(REG_CS_N, 1, 0, "CS_N after reset");
		read_expect(REG_STATUS, 32'd1 << STAT_RX_EMPTY, 0, "STATUS after reset");
		// Nothing received yet
		read_expect(REG_DATA, 0, 1, "DATA with RX empty");
		close_test("reset values");
	endtask

	task automatic register_access();
		open_test();
		write_expect(REG_CLK_DIV, FAST_DIV, 0, "CLK_DIV write pslverr");
		read_expect(REG_CLK_DIV, FAST_DIV, 0, "CLK_DIV readback");
		write_expect(REG_CS_N, 0, 0, "CS_N write pslverr");
		read_expect(REG_CS_N, 0, 0, "CS_N readback");
		// Read only and unmapped
		write_expect(REG_STATUS, 32'hffff_ffff, 1, "STATUS write pslverr");
		write_expect(8'h80, 32'h1234, 1, "unmapped write pslverr");
		read_expect(8'h10, 0, 1, "unmapped read");
		read_expect(REG_CLK_DIV, FAST_DIV, 0, "CLK_DIV after bad writes");
		read_expect(REG_CS_N, 0, 0, "CS_N after bad writes");
		read_expect(REG_STATUS, 32'd1 << STAT_RX_EMPTY, 0, "STATUS after bad writes");
		close_test("register access");
	endtask

	task automatic single_transfer();
		logic [7:0] b;
		open_test();
		next_rand_byte(b);
		send_byte(b, 0);
		wait_idle();
		check_model_log();
		drain_rx(1);
		close_test("single transfer");
	endtask

	task automatic burst_overflow();
		logic [7:0] b;
		open_test();
		write_expect(REG_CLK_DIV, BURST_DIV, 0, "CLK_DIV write pslverr");
		// One byte in the shifter plus a full TX, the next one bounces
		for (int i = 0; i < TX_DEPTH + 2; i++) begin
			next_rand_byte(b);
			send_byte(b, i == TX_DEPTH + 1);
		end
		wait_rx_full();
		drain_rx(RX_DEPTH);
		wait_idle();
		drain_rx(1);
		check_model_log();
		close_test("burst and TX overflow");
	endtask

	task automatic rx_backpressure();
		logic [7:0] b;
		int         base;
		open_test();
		write_expect(REG_CLK_DIV, FAST_DIV, 0, "CLK_DIV write pslverr");
		base = sent_hist.size();
		for (int i = 0; i < 4; i++) begin
			next_rand_byte(b);
			send_byte(b, 0);
		end
		wait_rx_full();
		// Second group parks in TX
		for (int i = 0; i < 4; i++) begin
			next_rand_byte(b);
			send_byte(b, 0);
		end
		repeat (4 * 16 * FAST_DIV) @(posedge apb);
		check("model bytes while stalled", i_spi_device_model.mosi_log.size(), base + 4);
		read_expect(REG_STATUS,
			(32'd1 << STAT_BUSY) | (32'd1 << STAT_TX_FULL) |
			(32'(TX_DEPTH) << STAT_TX_LVL_LSB) | (32'(RX_DEPTH) << STAT_RX_LVL_LSB),
			0, "STATUS while stalled");
		drain_rx(4);
		wait_idle();
		drain_rx(4);
		check_model_log();
		close_test("RX back-pressure");
	endtask

	task automatic chip_select_follow();
		logic [7:0] b;
		int         base;
		open_test();
		write_expect(REG_CS_N, 1, 0, "CS_N write pslverr");
		check("spi_cs_n after CS_N=1", spi_cs_n, 1);
		base = cs_changes;
		write_expect(REG_CS_N, 0, 0, "CS_N write pslverr");
		check("spi_cs_n after CS_N=0", spi_cs_n, 0);
		check("cs edges after CS_N=0", cs_changes, base + 1);
		// Pin must hold through a whole transfer
		next_rand_byte(b);
		send_byte(b, 0);
		wait_idle();
		drain_rx(1);
		check("spi_cs_n after transfer", spi_cs_n, 0);
		check("cs edges during transfer", cs_changes, base + 1);
		write_expect(REG_CS_N, 1, 0, "CS_N write pslverr");
		check("spi_cs_n back high", spi_cs_n, 1);
		check("cs edges after release", cs_changes, base + 2);
		close_test("chip select");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sequence

	initial begin : main
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (2) @(posedge apb);
		#2;
		rst_n = 1'b1;

		reset_values();
		register_access();
		single_transfer();
		burst_overflow();
		rx_backpressure();
		chip_select_follow();

		repeat (2) @(posedge apb);
		$display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hdl/spi_pkg.sv
hdl/byte_stream_if.sv
hdl/byte_fifo.sv
hdl/spi_apb_regs.sv
hdl/spi_shifter.sv
hdl/spi_host_top.sv
testbench/spi_device_model.sv
testbench/tb_spi_host.sv
